// File: filelist.f
hw/rvPkg.sv
hw/instrFetch.sv
hw/instrQueue.sv
hw/controlUnit.sv
hw/aluUnit.sv
hw/regFile.sv
hw/execUnit.sv
hw/coreTop.sv
bench/coreTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module coreTb -f filelist.f -o coreSim

out=$(./obj_dir/coreSim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "Finished with no errors"; then
   exit 0
fi
exit 1

// File: bench/progInput.txt
// @000 program words in fetch order   @080 dmem preload as byte address then value
// @0a0 retire records two per line as pc rd we value   pc ffffffff ends the list
@000
ffb00093 00c00113 002081b3 40208233 0020f2b3 0020e333 0020c3b3 0020a433
0020b4b3 0f00c513 fff12593 fff13613 07f0f693 f0016713 001117b3 0020d833
4020d8b3 00411913 01c25993 40225a13 12345ab7 00001b17 10000b93 004ba423
008bac03 000bac83 00218463 00219463 00100d13 0020c463 00200d13 0020d463
0020e463 0020f463 00300d13 00210463 00400d13 00211463 00114463 00115463
00500d13 00116463 00600d13 00117463 00c00def 00700d13 00800d13 010d8e67
00900d13 00000073
@080
00000100 cafef00d
ffffffff 00000000
@0a0
00000000 01 1 fffffffb  00000004 02 1 0000000c
00000008 03 1 00000007  0000000c 04 1 ffffffef
00000010 05 1 00000008  00000014 06 1 ffffffff
00000018 07 1 fffffff7  0000001c 08 1 00000001
00000020 09 1 00000000  00000024 0a 1 ffffff0b
00000028 0b 1 00000000  0000002c 0c 1 00000001
00000030 0d 1 0000007b  00000034 0e 1 ffffff0c
00000038 0f 1 60000000  0000003c 10 1 000fffff
00000040 11 1 ffffffff  00000044 12 1 000000c0
00000048 13 1 0000000f  0000004c 14 1 fffffffb
00000050 15 1 12345000  00000054 16 1 00001054
00000058 17 1 00000100  0000005c 00 0 00000000
00000060 18 1 ffffffef  00000064 19 1 cafef00d
00000068 00 0 00000000  0000006c 00 0 00000000
00000074 00 0 00000000  0000007c 00 0 00000000
00000080 00 0 00000000  00000084 00 0 00000000
0000008c 00 0 00000000  00000094 00 0 00000000
00000098 00 0 00000000  0000009c 00 0 00000000
000000a4 00 0 00000000  000000ac 00 0 00000000
000000b0 1b 1 000000b4  000000bc 1c 1 000000c0
000000c4 00 0 00000000  ffffffff 00 0 00000000

// File: bench/coreTb.sv
`timescale 1ns/1ps
`default_nettype none

module coreTb import rvPkg::*; ();

   localparam int   FileWords     = 512;
   localparam int   ImemWords     = 128;
   localparam int   DmemWords     = 256;
   localparam int   PreloadBase   = 'h080;
   localparam int   RecordBase    = 'h0a0;
   localparam int   RetireTimeout = 100;
   localparam int   QuietCycles   = 50;
   localparam wordT EndMark       = 32'hffffffff;

   logic    clk;
   logic    arstN;
   wordT    imemAddr;
   wordT    imemData;
   wordT    dmemAddr;
   wordT    dmemWdata;
   logic    dmemWe;
   wordT    dmemRdata;
   logic    retireValid;
   logic    retireWe;
   wordT    retirePc;
   wordT    retireData;
   regAddrT retireRd;
   logic    halted;

   wordT inputWords [FileWords];
   wordT imem       [ImemWords];
   wordT dmem       [DmemWords];

   coreTop #(
      .QueueDepth(4),
      .ResetPc(32'h0)
   ) DUT (
      .clk(clk),
      .arstN(arstN),
      .imemAddr(imemAddr),
      .imemData(imemData),
      .dmemAddr(dmemAddr),
      .dmemWdata(dmemWdata),
      .dmemWe(dmemWe),
      .dmemRdata(dmemRdata),
      .retireValid(retireValid),
      .retireWe(retireWe),
      .retirePc(retirePc),
      .retireData(retireData),
      .retireRd(retireRd),
      .halted(halted)
   );

   // both memories answer in the same cycle
   assign imemData  = imem[imemAddr[8:2]];
   assign dmemRdata = dmem[dmemAddr[9:2]];

   always @(posedge clk) begin
      if (dmemWe) begin
         dmem[dmemAddr[9:2]] <= dmemWdata;
      end
   end

   initial begin
      clk = 1'b0;
   end

   always #4 clk = ~clk;

   function automatic wordT fileWord(input int addr);
      return inputWords[addr[8:0]];
   endfunction

   task automatic abortRun(input string reason);
      $display("%s", reason);
      $display("Finished with errors");
      $fatal(1, "simulation stopped at the first failure");
   endtask

   task automatic loadInput();
      wordT addr;
      int   p;
      for (int i = 0; i < FileWords; i++) begin
         inputWords[i[8:0]] = '0;
      end
      $readmemh("bench/progInput.txt", inputWords);
      for (int i = 0; i < ImemWords; i++) begin
         imem[i[6:0]] = fileWord(i);
      end
      // words never preloaded hold noise
      for (int i = 0; i < DmemWords; i++) begin
         dmem[i[7:0]] <= $urandom();
      end
      p = PreloadBase;
      while (p < RecordBase && fileWord(p) != EndMark) begin
         addr = fileWord(p);
         dmem[addr[9:2]] <= fileWord(p + 1);
         p += 2;
      end
   endtask

   task automatic waitRetire(input int recNum);
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (!retireValid && cycles < RetireTimeout) begin
         @(negedge clk);
         cycles++;
      end
      assert (retireValid) else begin
         abortRun($sformatf("core stalled, no retire for record %0d within %0d cycles",
                            recNum, RetireTimeout));
      end
   endtask

   task automatic checkField(input int recNum, input string field, input wordT expVal,
                             input wordT actVal);
      assert (actVal == expVal) else begin
         abortRun($sformatf("Error: record %0d %s expected %h actual %h",
                            recNum, field, expVal, actVal));
      end
   endtask

   // rd and value only mean something when the record writes a register
   task automatic checkRecord(input int recNum, input int base);
      wordT expPc;
      wordT expRd;
      wordT expWe;
      wordT expData;
      expPc   = fileWord(base);
      expRd   = fileWord(base + 1);
      expWe   = fileWord(base + 2);
      expData = fileWord(base + 3);
      checkField(recNum, "pc", expPc, retirePc);
      checkField(recNum, "we", expWe, 32'(retireWe));
      if (expWe != '0) begin
         checkField(recNum, "rd", expRd, 32'(retireRd));
         checkField(recNum, "data", expData, retireData);
      end
   endtask

   task automatic waitHalted();
      int cycles;
      cycles = 0;
      while (!halted && cycles < RetireTimeout) begin
         @(negedge clk);
         cycles++;
      end
      assert (halted) else begin
         abortRun("halted did not rise after the last record");
      end
   endtask

   task automatic checkQuiet();
      for (int i = 0; i < QuietCycles; i++) begin
         @(negedge clk);
         assert (!retireValid && halted) else begin
            abortRun("core retired again or left halt after ecall");
         end
      end
   endtask

   initial begin
      int recNum;
      int base;
      arstN = 1'b0;
      void'($urandom(32'hb64f));
      loadInput();
      repeat (10) begin
         @(posedge clk);
      end
      #1 arstN = 1'b1;
      recNum = 0;
      base   = RecordBase;
      while (base + 3 < FileWords && fileWord(base) != EndMark) begin
         waitRetire(recNum);
         checkRecord(recNum, base);
         recNum++;
         base += 4;
      end
      waitHalted();
      checkQuiet();
      $display("Finished with no errors");
      $finish;
   end

endmodule

`default_nettype wire

// File: hw/coreTop.sv
`timescale 1ns/1ps
`default_nettype none

module coreTop import rvPkg::*; #(
   parameter int   QueueDepth = 4,
   parameter wordT ResetPc    = '0
) (
   input  wire logic clk,
   input  wire logic arstN,
   output wordT      imemAddr,
   input  wordT      imemData,
   output wordT      dmemAddr,
   output wordT      dmemWdata,
   output logic      dmemWe,
   input  wordT      dmemRdata,
   output logic      retireValid,
   output logic      retireWe,
   output wordT      retirePc,
   output wordT      retireData,
   output regAddrT   retireRd,
   output logic      halted
);

   logic fetchReq;
   logic fetchAck;
   logic issueReq;
   logic issueAck;
   logic flush;
   wordT fetchPc;
   wordT fetchInstr;
   wordT issuePc;
   wordT issueInstr;
   wordT redirectPc;

   instrFetch #(.ResetPc(ResetPc)) uFetch (
      .clk(clk), .arstN(arstN), .imemAddr(imemAddr), .imemData(imemData),
      .fetchReq(fetchReq), .fetchAck(fetchAck), .fetchPc(fetchPc),
      .fetchInstr(fetchInstr), .flush(flush), .redirectPc(redirectPc),
      .halted(halted)
   );

   instrQueue #(.QueueDepth(QueueDepth)) uQueue (
      .clk(clk), .arstN(arstN), .fetchReq(fetchReq), .fetchAck(fetchAck),
      .fetchPc(fetchPc), .fetchInstr(fetchInstr), .issueReq(issueReq),
      .issueAck(issueAck), .issuePc(issuePc), .issueInstr(issueInstr), .flush(flush)
   );

   execUnit uExec (
      .clk(clk), .arstN(arstN), .issueReq(issueReq), .issueAck(issueAck),
      .issuePc(issuePc), .issueInstr(issueInstr), .flush(flush),
      .redirectPc(redirectPc), .dmemAddr(dmemAddr), .dmemWdata(dmemWdata),
      .dmemWe(dmemWe), .dmemRdata(dmemRdata), .retireValid(retireValid),
      .retireWe(retireWe), .retirePc(retirePc), .retireData(retireData),
      .retireRd(retireRd), .halted(halted)
   );

endmodule

`default_nettype wire

// File: hw/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

module execUnit import rvPkg::*; (
   input  wire logic clk,
   input  wire logic arstN,
   input  wire logic issueReq,
   output logic      issueAck,
   input  wordT      issuePc,
   input  wordT      issueInstr,
   output logic      flush,
   output wordT      redirectPc,
   output wordT      dmemAddr,
   output wordT      dmemWdata,
   output logic      dmemWe,
   input  wordT      dmemRdata,
   output logic      retireValid,
   output logic      retireWe,
   output wordT      retirePc,
   output wordT      retireData,
   output regAddrT   retireRd,
   output logic      halted
);

   execStateT state;
   wordT      instrQ;
   wordT      pcQ;
   wordT      imm;
   wordT      rd1Data;
   wordT      rd2Data;
   wordT      srcB;
   wordT      aluResult;
   wordT      wbData;
   wordT      target;
   aluOpT     aluCtrl;
   immSelT    immSrc;
   logic      aluZero;
   logic      aluSrc;
   logic      pcSrc;
   logic      regWrite;
   logic      memWrite;
   logic      resultSrc;
   logic      executing;
   logic [6:0] opcode;
   regAddrT   rdAddr;

   assign opcode    = instrQ[6:0];
   assign rdAddr    = instrQ[11:7];
   assign executing = (state == stExecute);
   assign halted    = (state == stHalted);

   controlUnit uCtrl (
      .instr(instrQ), .aluZero(aluZero), .aluCtrl(aluCtrl), .aluSrc(aluSrc),
      .immSrc(immSrc), .pcSrc(pcSrc), .regWrite(regWrite), .memWrite(memWrite),
      .resultSrc(resultSrc)
   );

   regFile uRegs (
      .clk(clk), .arstN(arstN), .rs1(instrQ[19:15]), .rs2(instrQ[24:20]),
      .rd(rdAddr), .rd1(rd1Data), .rd2(rd2Data), .we(executing && regWrite),
      .wd(wbData)
   );

   assign srcB = aluSrc ? imm : rd2Data;

   aluUnit uAlu (
      .aluCtrl(aluCtrl), .srcA(rd1Data), .srcB(srcB), .result(aluResult),
      .zero(aluZero)
   );

   always_comb begin
      case (immSrc)
         immI:      imm = {{20{instrQ[31]}}, instrQ[31:20]};
         immIShamt: imm = {27'b0, instrQ[24:20]};
         immS:      imm = {{20{instrQ[31]}}, instrQ[31:25], instrQ[11:7]};
         immB:      imm = {{19{instrQ[31]}}, instrQ[31], instrQ[7], instrQ[30:25],
                           instrQ[11:8], 1'b0};
         immU:      imm = {instrQ[31:12], 12'b0};
         immJ:      imm = {{11{instrQ[31]}}, instrQ[31], instrQ[19:12], instrQ[20],
                           instrQ[30:21], 1'b0};
         default:   imm = '0;
      endcase
   end

   // store lands on the edge that closes execute
   assign dmemAddr  = aluResult;
   assign dmemWdata = rd2Data;
   assign dmemWe    = executing && memWrite;

   always_comb begin
      if (opcode == opJal || opcode == opJalr) begin
         wbData = pcQ + 32'd4;
      end else if (opcode == opAuipc) begin
         wbData = pcQ + imm;
      end else if (resultSrc) begin
         wbData = dmemRdata;
      end else begin
         wbData = aluResult;
      end
   end

   assign target = (opcode == opJalr) ? {aluResult[31:1], 1'b0} : pcQ + imm;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         state       <= stIdle;
         issueAck    <= 1'b0;
         retireValid <= 1'b0;
         flush       <= 1'b0;
      end else begin
         retireValid <= 1'b0;
         flush       <= 1'b0;
         case (state)
            stIdle: begin
               if (issueReq) begin
                  state <= stExecute;
               end
            end
            stExecute: begin
               retireValid <= 1'b1;
               // ecall and ebreak stop the core for good
               if (opcode == opSystem) begin
                  state <= stHalted;
               end else begin
                  issueAck <= 1'b1;
                  flush    <= pcSrc;
                  state    <= stAck;
               end
            end
            stAck: begin
               if (!issueReq) begin
                  issueAck <= 1'b0;
                  state    <= stIdle;
               end
            end
            default: state <= stHalted;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == stIdle && issueReq) begin
         instrQ <= issueInstr;
         pcQ    <= issuePc;
      end
      if (executing) begin
         retirePc   <= pcQ;
         retireRd   <= rdAddr;
         retireData <= wbData;
         retireWe   <= regWrite && rdAddr != '0;
         redirectPc <= target;
      end
   end

endmodule

`default_nettype wire

// File: hw/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile import rvPkg::*; (
   input  wire logic clk,
   input  wire logic arstN,
   input  regAddrT   rs1,
   input  regAddrT   rs2,
   input  regAddrT   rd,
   output wordT      rd1,
   output wordT      rd2,
   input  wire logic we,
   input  wordT      wd
);

   wordT regs [32];

   assign rd1 = regs[rs1];
   assign rd2 = regs[rs2];

   // x0 never written so it reads zero
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         regs <= '{default: '0};
      end else if (we && rd != '0) begin
         regs[rd] <= wd;
      end
   end

endmodule

`default_nettype wire

// File: hw/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit import rvPkg::*; (
   input  aluOpT aluCtrl,
   input  wordT  srcA,
   input  wordT  srcB,
   output wordT  result,
   output logic  zero
);

   logic [4:0] shamt;

   assign shamt = srcB[4:0];

   always_comb begin
      case (aluCtrl)
         aluAdd:   result = srcA + srcB;
         aluSub:   result = srcA - srcB;
         aluAnd:   result = srcA & srcB;
         aluOr:    result = srcA | srcB;
         aluXor:   result = srcA ^ srcB;
         aluSll:   result = srcA << shamt;
         aluSrl:   result = srcA >> shamt;
         // sign fill
         aluSra:   result = wordT'($signed(srcA) >>> shamt);
         aluSlt:   result = {31'b0, $signed(srcA) < $signed(srcB)};
         aluSltu:  result = {31'b0, srcA < srcB};
         aluPassB: result = srcB;
         default:  result = '0;
      endcase
   end

   // also the branch condition for slt based compares
   assign zero = (result == '0);

endmodule

`default_nettype wire

// File: hw/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit import rvPkg::*; (
   input  wordT      instr,
   input  wire logic aluZero,
   output aluOpT     aluCtrl,
   output logic      aluSrc,
   output immSelT    immSrc,
   output logic      pcSrc,
   output logic      regWrite,
   output logic      memWrite,
   output logic      resultSrc
);

   logic [6:0] op;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic       isBranch;
   logic       isJump;
   logic       takeOnZero;

   assign op     = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   // branch taken when the flag matches the wanted sense
   assign pcSrc = isJump || (isBranch && (aluZero == takeOnZero));

   always_comb begin
      aluCtrl    = aluAdd;
      aluSrc     = 1'b0;
      immSrc     = immI;
      regWrite   = 1'b0;
      memWrite   = 1'b0;
      resultSrc  = 1'b0;
      isBranch   = 1'b0;
      isJump     = 1'b0;
      takeOnZero = 1'b0;
      case (op)
         opR, opI: begin
            regWrite = 1'b1;
            aluSrc   = (op == opI);
            case (funct3)
               3'b000: begin
                  // subtract only exists in the register form
                  if (op == opR && funct7 == 7'h20) begin
                     aluCtrl = aluSub;
                  end else if (op == opR && funct7 != 7'h00) begin
                     regWrite = 1'b0;
                  end
               end
               3'b110: aluCtrl = aluOr;
               3'b100: aluCtrl = aluXor;
               3'b111: aluCtrl = aluAnd;
               3'b010: aluCtrl = aluSlt;
               3'b011: aluCtrl = aluSltu;
               3'b001: begin
                  immSrc  = immIShamt;
                  aluCtrl = aluSll;
               end
               3'b101: begin
                  immSrc = immIShamt;
                  case (funct7)
                     7'h00:   aluCtrl = aluSrl;
                     7'h20:   aluCtrl = aluSra;
                     default: regWrite = 1'b0;
                  endcase
               end
               default: regWrite = 1'b0;
            endcase
         end
         // word access only
         opLoad: begin
            aluSrc    = 1'b1;
            resultSrc = 1'b1;
            regWrite  = (funct3 == 3'b010);
         end
         opStore: begin
            aluSrc   = 1'b1;
            immSrc   = immS;
            memWrite = (funct3 == 3'b010);
         end
         opBranch: begin
            immSrc   = immB;
            isBranch = 1'b1;
            case (funct3)
               3'b000: begin
                  aluCtrl    = aluSub;
                  takeOnZero = 1'b1;
               end
               3'b001: aluCtrl = aluSub;
               3'b100: aluCtrl = aluSlt;
               3'b101: begin
                  aluCtrl    = aluSlt;
                  takeOnZero = 1'b1;
               end
               3'b110: aluCtrl = aluSltu;
               3'b111: begin
                  aluCtrl    = aluSltu;
                  takeOnZero = 1'b1;
               end
               default: isBranch = 1'b0;
            endcase
         end
         opJal: begin
            immSrc   = immJ;
            isJump   = 1'b1;
            regWrite = 1'b1;
         end
         // target is rs1 + imm through the ALU
         opJalr: begin
            aluSrc   = 1'b1;
            isJump   = 1'b1;
            regWrite = 1'b1;
         end
         opLui: begin
            aluSrc   = 1'b1;
            immSrc   = immU;
            aluCtrl  = aluPassB;
            regWrite = 1'b1;
         end
         opAuipc: begin
            immSrc   = immU;
            regWrite = 1'b1;
         end
         default: begin
            regWrite = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: hw/instrQueue.sv
`timescale 1ns/1ps
`default_nettype none

module instrQueue import rvPkg::*; #(
   parameter int QueueDepth = 4
) (
   input  wire logic clk,
   input  wire logic arstN,
   input  wire logic fetchReq,
   output logic      fetchAck,
   input  wordT      fetchPc,
   input  wordT      fetchInstr,
   output logic      issueReq,
   input  wire logic issueAck,
   output wordT      issuePc,
   output wordT      issueInstr,
   input  wire logic flush
);

   localparam int PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
   localparam int CntW = $clog2(QueueDepth + 1);

   wordT pcMem    [QueueDepth];
   wordT instrMem [QueueDepth];

   logic [PtrW-1:0] wrPtr;
   logic [PtrW-1:0] rdPtr;
   logic [CntW-1:0] count;
   logic            full;
   logic            pushEn;
   logic            popEn;

   assign full   = (count == CntW'(QueueDepth));
   assign pushEn = fetchReq && !fetchAck && !full && !flush;
   assign popEn  = issueReq && issueAck && !flush;

   assign issuePc    = pcMem[rdPtr];
   assign issueInstr = instrMem[rdPtr];

   always_ff @(posedge clk) begin
      if (pushEn) begin
         pcMem[wrPtr]    <= fetchPc;
         instrMem[wrPtr] <= fetchInstr;
      end
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         wrPtr    <= '0;
         rdPtr    <= '0;
         count    <= '0;
         fetchAck <= 1'b0;
         issueReq <= 1'b0;
      end else if (flush) begin
         wrPtr    <= '0;
         rdPtr    <= '0;
         count    <= '0;
         fetchAck <= 1'b0;
         issueReq <= 1'b0;
      end else begin
         // input side
         if (pushEn) begin
            fetchAck <= 1'b1;
            wrPtr    <= (wrPtr == PtrW'(QueueDepth - 1)) ? '0 : wrPtr + 1'b1;
         end else if (fetchAck && !fetchReq) begin
            fetchAck <= 1'b0;
         end
         // output side
         if (popEn) begin
            issueReq <= 1'b0;
            rdPtr    <= (rdPtr == PtrW'(QueueDepth - 1)) ? '0 : rdPtr + 1'b1;
         end else if (!issueReq && !issueAck && count != '0) begin
            issueReq <= 1'b1;
         end
         if (pushEn && !popEn) begin
            count <= count + 1'b1;
         end else if (popEn && !pushEn) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/instrFetch.sv
`timescale 1ns/1ps
`default_nettype none

module instrFetch import rvPkg::*; #(
   parameter wordT ResetPc = '0
) (
   input  wire logic clk,
   input  wire logic arstN,
   output wordT      imemAddr,
   input  wordT      imemData,
   output logic      fetchReq,
   input  wire logic fetchAck,
   output wordT      fetchPc,
   output wordT      fetchInstr,
   input  wire logic flush,
   input  wordT      redirectPc,
   input  wire logic halted
);

   wordT pc;
   logic startReq;

   assign imemAddr = pc;

   // new request only once the previous ack has fallen
   assign startReq = !fetchReq && !fetchAck && !flush && !halted;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pc       <= ResetPc;
         fetchReq <= 1'b0;
      end else if (flush) begin
         pc       <= redirectPc;
         fetchReq <= 1'b0;
      end else if (fetchReq) begin
         if (fetchAck) begin
            fetchReq <= 1'b0;
            pc       <= pc + 32'd4;
         end
      end else if (startReq) begin
         fetchReq <= 1'b1;
      end
   end

   // held stable for the whole request phase
   always_ff @(posedge clk) begin
      if (startReq) begin
         fetchPc    <= pc;
         fetchInstr <= imemData;
      end
   end

endmodule

`default_nettype wire

// File: hw/rvPkg.sv
`default_nettype none

package rvPkg;

   typedef logic [31:0] wordT;
   typedef logic [4:0]  regAddrT;

   typedef enum logic [3:0] {
      aluAdd,
      aluSub,
      aluAnd,
      aluOr,
      aluXor,
      aluSll,
      aluSrl,
      aluSra,
      aluSlt,
      aluSltu,
      aluPassB
   } aluOpT;

   // immediate layouts
   // immIShamt carries only the 5 bit shift amount
   typedef enum logic [2:0] {
      immI,
      immIShamt,
      immS,
      immB,
      immU,
      immJ
   } immSelT;

   typedef enum logic [1:0] {
      stIdle,
      stExecute,
      stAck,
      stHalted
   } execStateT;

   // major opcodes
   localparam logic [6:0] opR      = 7'b0110011;
   localparam logic [6:0] opI      = 7'b0010011;
   localparam logic [6:0] opLoad   = 7'b0000011;
   localparam logic [6:0] opStore  = 7'b0100011;
   localparam logic [6:0] opBranch = 7'b1100011;
   localparam logic [6:0] opJal    = 7'b1101111;
   localparam logic [6:0] opJalr   = 7'b1100111;
   localparam logic [6:0] opLui    = 7'b0110111;
   localparam logic [6:0] opAuipc  = 7'b0010111;
   localparam logic [6:0] opSystem = 7'b1110011;

endpackage

`default_nettype wire
